// ==== verilog.f ====
logic/dfr_pkg.sv
logic/dfr_mem_if.sv
logic/dfr_dpram.sv
logic/dfr_host_regs.sv
logic/dfr_controller.sv
logic/dfr_reservoir.sv
logic/dfr_readout.sv
logic/dfr_core_top.sv
tb/dfr_core_assert.sv
tb/dfr_core_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = dfr_core_tb
FILELIST = verilog.f
LOG      = sim.log
FAIL_MSG = Test failed

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	test $$status -eq 0 && ! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb/dfr_core_tb.sv ====
`timescale 1ns/1ps

module dfr_core_tb;

    localparam int TIMEOUT = 2000;   // Cycles per wait

    logic                clk;
    logic                rst_n;
    dfr_pkg::host_addr_t host_addr;
    logic                host_wen;
    logic                host_ren;
    dfr_pkg::host_data_t host_wdata;
    dfr_pkg::host_data_t host_rdata;
    logic                host_rvalid;
    logic                busy;
    logic                done;

    integer              seed = 32'h8195_8380;
    int                  error_count;
    int                  timeout_count;
    int                  check_count;
    dfr_pkg::host_data_t rdata;
    dfr_pkg::sample_t    samples [dfr_pkg::MAX_SAMPLES];
    dfr_pkg::weight_t    weights [dfr_pkg::NUM_NODES];
    dfr_pkg::state_t     exp_states [dfr_pkg::MAX_SAMPLES * dfr_pkg::NUM_NODES];
    dfr_pkg::state_t     exp_outputs [dfr_pkg::MAX_SAMPLES];

    dfr_core_top dut_i (
        .s_axi_aclk_i(clk), .rst_n_i(rst_n),
        .host_addr_i(host_addr), .host_wen_i(host_wen), .host_ren_i(host_ren),
        .host_wdata_i(host_wdata), .host_rdata_o(host_rdata), .host_rvalid_o(host_rvalid),
        .busy_o(busy), .done_o(done)
    );

    always #50 clk = ~clk;

    // Each node sees the node one sample back, halved, plus its own sample
    function automatic void ref_run(input int count);
        longint acc;
        for (int t = 0; t < count * dfr_pkg::NUM_NODES; t++) begin
            exp_states[t] = dfr_pkg::state_t'(samples[t / dfr_pkg::NUM_NODES]);
            if (t >= dfr_pkg::NUM_NODES) begin
                exp_states[t] = exp_states[t] + (exp_states[t - dfr_pkg::NUM_NODES] >>> 1);
            end
        end
        for (int k = 0; k < count; k++) begin
            acc = 0;
            for (int n = 0; n < dfr_pkg::NUM_NODES; n++) begin
                acc = acc + longint'(exp_states[k * dfr_pkg::NUM_NODES + n]) *
                            longint'(weights[n]);
            end
            exp_outputs[k] = dfr_pkg::state_t'(acc[31:0]);   // Low 32 bits only
        end
    endfunction

    task automatic check_word(input dfr_pkg::state_t actual, input dfr_pkg::state_t expected,
                              input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic host_write(input logic [dfr_pkg::REGION_W-1:0] region,
                              input logic [dfr_pkg::OFFSET_W-1:0] offset,
                              input dfr_pkg::host_data_t data);
        host_addr  = {region, offset};
        host_wdata = data;
        host_wen   = 1'b1;
        @(posedge clk);
        #1;
        host_wen = 1'b0;
    endtask

    task automatic host_read(input logic [dfr_pkg::REGION_W-1:0] region,
                             input logic [dfr_pkg::OFFSET_W-1:0] offset,
                             output dfr_pkg::host_data_t data);
        int waited;
        waited    = 0;
        host_addr = {region, offset};
        host_ren  = 1'b1;
        @(posedge clk);
        #1;
        host_ren = 1'b0;
        while (!host_rvalid && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!host_rvalid) begin
            timeout_count++;
            $display("Timeout at %0t ns: no read data returned", $time);
        end
        data = host_rdata;
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        while (busy && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (busy) begin
            timeout_count++;
            $display("Timeout at %0t ns: the run never finished", $time);
        end
    endtask

    task automatic load_weights();
        for (int n = 0; n < dfr_pkg::NUM_NODES; n++) begin
            weights[n] = dfr_pkg::weight_t'($random(seed));
            host_write(dfr_pkg::WEIGHT_REGION, dfr_pkg::OFFSET_W'(n),
                       dfr_pkg::host_data_t'(weights[n]));
        end
        for (int n = 0; n < dfr_pkg::NUM_NODES; n++) begin
            host_read(dfr_pkg::WEIGHT_REGION, dfr_pkg::OFFSET_W'(n), rdata);
            check_word(rdata, dfr_pkg::state_t'(weights[n]), $sformatf("weight %0d", n));
        end
    endtask

    task automatic load_inputs(input int count);
        for (int i = 0; i < count; i++) begin
            samples[i] = dfr_pkg::sample_t'($random(seed));
            host_write(dfr_pkg::INPUT_REGION, dfr_pkg::OFFSET_W'(i),
                       dfr_pkg::host_data_t'(samples[i]));
        end
        for (int i = 0; i < count; i++) begin
            host_read(dfr_pkg::INPUT_REGION, dfr_pkg::OFFSET_W'(i), rdata);
            check_word(rdata, dfr_pkg::state_t'(samples[i]), $sformatf("sample %0d", i));
        end
    endtask

    task automatic start_run(input int count);
        host_write(dfr_pkg::REG_REGION, dfr_pkg::COUNT_REG, dfr_pkg::host_data_t'(count));
        host_write(dfr_pkg::REG_REGION, dfr_pkg::CTRL_REG, 32'h1);
        check_flag(busy, 1'b1, "busy_o after start");
    endtask

    task automatic compare_results(input int count);
        ref_run(count);
        for (int t = 0; t < count * dfr_pkg::NUM_NODES; t++) begin
            host_read(dfr_pkg::STATE_REGION, dfr_pkg::OFFSET_W'(t), rdata);
            check_word(rdata, exp_states[t], $sformatf("state %0d", t));
        end
        for (int k = 0; k < count; k++) begin
            host_read(dfr_pkg::OUTPUT_REGION, dfr_pkg::OFFSET_W'(k), rdata);
            check_word(rdata, exp_outputs[k], $sformatf("output %0d", k));
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        host_addr     = '0;
        host_wen      = 1'b0;
        host_ren      = 1'b0;
        host_wdata    = '0;
        error_count   = 0;
        timeout_count = 0;
        check_count   = 0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_flag(busy, 1'b0, "busy_o after reset");
        check_flag(done, 1'b0, "done_o after reset");
        check_flag(host_rvalid, 1'b0, "host_rvalid_o after reset");
        host_read(dfr_pkg::REG_REGION, dfr_pkg::STATUS_REG, rdata);
        check_word(rdata, 0, "status after reset");

        load_weights();
        load_inputs(12);
        start_run(12);
        // Memory windows closed while the core runs
        host_read(dfr_pkg::INPUT_REGION, 12'd0, rdata);
        check_word(rdata, 0, "input read while busy");
        host_write(dfr_pkg::INPUT_REGION, 12'd0, dfr_pkg::host_data_t'(~samples[0]));
        host_read(dfr_pkg::REG_REGION, dfr_pkg::STATUS_REG, rdata);
        check_flag(rdata[0], 1'b1, "status busy bit while running");
        wait_done();
        check_flag(done, 1'b1, "done_o after run");
        host_read(dfr_pkg::REG_REGION, dfr_pkg::STATUS_REG, rdata);
        check_flag(rdata[0], 1'b0, "status busy bit after run");
        check_flag(rdata[1], 1'b1, "status done bit after run");
        compare_results(12);
        host_read(dfr_pkg::INPUT_REGION, 12'd0, rdata);
        check_word(rdata, dfr_pkg::state_t'(samples[0]), "sample 0 after write while busy");

        // Second run must start from a cleared ring
        load_inputs(5);
        start_run(5);
        wait_done();
        check_flag(done, 1'b1, "done_o after second run");
        compare_results(5);

        $display("Checks: %0d, errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tb/dfr_core_assert.sv ====
`timescale 1ns/1ps

module dfr_core_assert (
    input logic clk_i,
    input logic rst_n_i,
    input logic readout_start_i,
    input logic busy_i,
    input logic done_i
);

    // Controller comes out of reset idle
    idle_after_reset: assert property (@(posedge clk_i) !rst_n_i |=> !busy_i)
        else $error("Controller busy in the cycle after reset");

    readout_in_run: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) readout_start_i |-> busy_i
    ) else $error("Readout started while the controller was idle");

    done_not_busy: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !(done_i && busy_i)
    ) else $error("done and busy high together");

endmodule

bind dfr_controller dfr_core_assert assert_i (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .readout_start_i(readout_start_o),
    .busy_i(busy_o), .done_i(done_o)
);

// ==== logic/dfr_core_top.sv ====
`timescale 1ns/1ps

module dfr_core_top (
    input  logic                s_axi_aclk_i,
    input  logic                rst_n_i,
    input  dfr_pkg::host_addr_t host_addr_i,
    input  logic                host_wen_i,
    input  logic                host_ren_i,
    input  dfr_pkg::host_data_t host_wdata_i,
    output dfr_pkg::host_data_t host_rdata_o,
    output logic                host_rvalid_o,
    output logic                busy_o,
    output logic                done_o
);

    logic                          start;
    logic [dfr_pkg::COUNT_W-1:0]   count;
    logic [dfr_pkg::SAMPLE_AW-1:0] sample_addr;
    logic                          step_valid;
    logic [dfr_pkg::STATE_AW-1:0]  step_addr;
    logic                          res_clear;
    logic                          readout_start;
    logic                          readout_busy;
    logic                          res_phase;

    dfr_mem_if #(.word_t(dfr_pkg::sample_t), .ADDR_W(dfr_pkg::SAMPLE_AW))
        input_a_if (), input_b_if ();
    dfr_mem_if #(.word_t(dfr_pkg::weight_t), .ADDR_W(dfr_pkg::WEIGHT_AW))
        weight_a_if (), weight_b_if ();
    dfr_mem_if #(.word_t(dfr_pkg::state_t), .ADDR_W(dfr_pkg::STATE_AW))
        state_a_if (), state_b_if (), res_state_if (), rdo_state_if ();
    dfr_mem_if #(.word_t(dfr_pkg::state_t), .ADDR_W(dfr_pkg::SAMPLE_AW))
        output_a_if (), output_b_if ();

    dfr_host_regs host_regs_i (
        .clk_i(s_axi_aclk_i), .rst_n_i(rst_n_i),
        .host_addr_i(host_addr_i), .host_wen_i(host_wen_i), .host_ren_i(host_ren_i),
        .host_wdata_i(host_wdata_i), .host_rdata_o(host_rdata_o),
        .host_rvalid_o(host_rvalid_o), .busy_i(busy_o), .done_i(done_o),
        .start_o(start), .count_o(count),
        .input_a(input_a_if), .weight_a(weight_a_if),
        .state_a(state_a_if), .output_a(output_a_if)
    );

    dfr_controller controller_i (
        .clk_i(s_axi_aclk_i), .rst_n_i(rst_n_i), .start_i(start), .count_i(count),
        .sample_addr_o(sample_addr), .step_valid_o(step_valid), .step_addr_o(step_addr),
        .res_clear_o(res_clear), .readout_start_o(readout_start),
        .readout_busy_i(readout_busy), .res_phase_o(res_phase),
        .busy_o(busy_o), .done_o(done_o)
    );

    // Input memory port b is read only
    assign input_b_if.addr  = sample_addr;
    assign input_b_if.wdata = '0;
    assign input_b_if.wen   = 1'b0;

    dfr_reservoir reservoir_i (
        .clk_i(s_axi_aclk_i), .rst_n_i(rst_n_i), .clear_i(res_clear),
        .step_valid_i(step_valid), .step_addr_i(step_addr),
        .sample_i(input_b_if.rdata), .state_wr(res_state_if)
    );

    dfr_readout readout_i (
        .clk_i(s_axi_aclk_i), .rst_n_i(rst_n_i), .start_i(readout_start), .count_i(count),
        .state_rd(rdo_state_if), .weight_rd(weight_b_if), .out_wr(output_b_if),
        .busy_o(readout_busy)
    );

    // State memory port b, reservoir writes then readout reads
    assign state_b_if.addr    = res_phase ? res_state_if.addr  : rdo_state_if.addr;
    assign state_b_if.wdata   = res_phase ? res_state_if.wdata : rdo_state_if.wdata;
    assign state_b_if.wen     = res_phase ? res_state_if.wen   : rdo_state_if.wen;
    assign res_state_if.rdata = state_b_if.rdata;
    assign rdo_state_if.rdata = state_b_if.rdata;

    dfr_dpram #(.word_t(dfr_pkg::sample_t), .DEPTH_AW(dfr_pkg::SAMPLE_AW)) input_mem (
        .clk_i(s_axi_aclk_i), .port_a(input_a_if), .port_b(input_b_if)
    );
    dfr_dpram #(.word_t(dfr_pkg::weight_t), .DEPTH_AW(dfr_pkg::WEIGHT_AW)) weight_mem (
        .clk_i(s_axi_aclk_i), .port_a(weight_a_if), .port_b(weight_b_if)
    );
    dfr_dpram #(.word_t(dfr_pkg::state_t), .DEPTH_AW(dfr_pkg::STATE_AW)) state_mem (
        .clk_i(s_axi_aclk_i), .port_a(state_a_if), .port_b(state_b_if)
    );
    dfr_dpram #(.word_t(dfr_pkg::state_t), .DEPTH_AW(dfr_pkg::SAMPLE_AW)) output_mem (
        .clk_i(s_axi_aclk_i), .port_a(output_a_if), .port_b(output_b_if)
    );

endmodule

// ==== logic/dfr_readout.sv ====
`timescale 1ns/1ps

module dfr_readout (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        start_i,
    input  logic [dfr_pkg::COUNT_W-1:0] count_i,
    dfr_mem_if.user                     state_rd,
    dfr_mem_if.user                     weight_rd,
    dfr_mem_if.user                     out_wr,
    output logic                        busy_o
);

    logic                          run_q;
    logic [dfr_pkg::COUNT_W-1:0]   count_q;
    logic [dfr_pkg::COUNT_W-1:0]   k_q;
    logic [dfr_pkg::WEIGHT_AW-1:0] n_q;
    logic                          issue;
    logic                          last_node;
    logic                          valid_d1;
    logic                          first_d1;
    logic                          last_d1;
    logic [dfr_pkg::SAMPLE_AW-1:0] k_d1;
    logic                          wen_q;
    dfr_pkg::state_t               acc_q;
    dfr_pkg::state_t               acc_sum;
    dfr_pkg::prod_t                prod;

    assign issue     = run_q && (k_q != count_q);
    assign last_node = (n_q == dfr_pkg::WEIGHT_AW'(dfr_pkg::NUM_NODES - 1));

    assign state_rd.addr   = dfr_pkg::STATE_AW'(k_q * dfr_pkg::NUM_NODES + n_q);
    assign state_rd.wdata  = '0;
    assign state_rd.wen    = 1'b0;
    assign weight_rd.addr  = n_q;
    assign weight_rd.wdata = '0;
    assign weight_rd.wen   = 1'b0;
    assign out_wr.wen      = wen_q;

    assign prod    = dfr_pkg::prod_t'(state_rd.rdata) * dfr_pkg::prod_t'(weight_rd.rdata);
    assign acc_sum = (first_d1 ? '0 : acc_q) + dfr_pkg::state_t'(prod[31:0]);   // Wraps
    assign busy_o  = run_q || valid_d1 || wen_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            run_q    <= 1'b0;
            count_q  <= '0;
            k_q      <= '0;
            n_q      <= '0;
            valid_d1 <= 1'b0;
            wen_q    <= 1'b0;
        end else begin
            valid_d1 <= issue;
            wen_q    <= valid_d1 && last_d1;
            if (start_i) begin
                run_q   <= 1'b1;
                count_q <= count_i;
                k_q     <= '0;
                n_q     <= '0;
            end else if (run_q) begin
                if (!issue) begin
                    run_q <= 1'b0;
                end else if (last_node) begin
                    n_q <= '0;
                    k_q <= k_q + 1'b1;
                end else begin
                    n_q <= n_q + 1'b1;
                end
            end
        end
    end

    // Read data arrives one cycle after issue
    always_ff @(posedge clk_i) begin
        first_d1 <= (n_q == '0);
        last_d1  <= last_node;
        k_d1     <= k_q[dfr_pkg::SAMPLE_AW-1:0];
        if (valid_d1) begin
            acc_q <= acc_sum;
        end
        out_wr.addr  <= k_d1;
        out_wr.wdata <= acc_sum;
    end

endmodule

// ==== logic/dfr_reservoir.sv ====
`timescale 1ns/1ps

module dfr_reservoir (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         clear_i,
    input  logic                         step_valid_i,
    input  logic [dfr_pkg::STATE_AW-1:0] step_addr_i,
    input  dfr_pkg::sample_t             sample_i,
    dfr_mem_if.user                      state_wr
);

    dfr_pkg::state_t ring_q [dfr_pkg::NUM_NODES];
    dfr_pkg::state_t new_state;

    // Oldest node feeds back, halved
    assign new_state = (ring_q[dfr_pkg::NUM_NODES-1] >>> 1) + dfr_pkg::state_t'(sample_i);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clear_i) begin
            ring_q <= '{default: '0};
        end else if (step_valid_i) begin
            ring_q[0] <= new_state;
            for (int i = 1; i < dfr_pkg::NUM_NODES; i++) begin
                ring_q[i] <= ring_q[i-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_wr.wen <= 1'b0;
        end else begin
            state_wr.wen <= step_valid_i;
        end
        state_wr.addr  <= step_addr_i;
        state_wr.wdata <= new_state;
    end

endmodule

// ==== logic/dfr_controller.sv ====
`timescale 1ns/1ps

module dfr_controller (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          start_i,
    input  logic [dfr_pkg::COUNT_W-1:0]   count_i,
    output logic [dfr_pkg::SAMPLE_AW-1:0] sample_addr_o,
    output logic                          step_valid_o,
    output logic [dfr_pkg::STATE_AW-1:0]  step_addr_o,
    output logic                          res_clear_o,
    output logic                          readout_start_o,
    input  logic                          readout_busy_i,
    output logic                          res_phase_o,
    output logic                          busy_o,
    output logic                          done_o
);

    typedef enum logic [2:0] {IDLE, RUN, DRAIN, READOUT, FINISH} phase_e;

    phase_e                       state_q;
    logic [dfr_pkg::COUNT_W-1:0]  count_q;
    logic [dfr_pkg::STEP_W-1:0]   step_q;
    logic [dfr_pkg::STEP_W-1:0]   total_steps;
    logic                         step_issue;
    logic                         rdo_busy_q;

    assign total_steps   = dfr_pkg::STEP_W'(count_q * dfr_pkg::NUM_NODES);
    assign step_issue    = (state_q == RUN) && (step_q != total_steps);
    assign sample_addr_o = dfr_pkg::SAMPLE_AW'(step_q / dfr_pkg::NUM_NODES);
    assign res_phase_o   = (state_q == RUN) || (state_q == DRAIN);   // State mem port b owner
    assign busy_o        = (state_q != IDLE);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q         <= IDLE;
            count_q         <= '0;
            step_q          <= '0;
            step_valid_o    <= 1'b0;
            res_clear_o     <= 1'b0;
            readout_start_o <= 1'b0;
            rdo_busy_q      <= 1'b0;
            done_o          <= 1'b0;
        end else begin
            step_valid_o    <= step_issue;   // Lines up with sample read data
            res_clear_o     <= 1'b0;
            readout_start_o <= 1'b0;
            rdo_busy_q      <= readout_busy_i;
            if (step_issue) begin
                step_q <= step_q + 1'b1;
            end
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q     <= RUN;
                        count_q     <= count_i;
                        step_q      <= '0;
                        res_clear_o <= 1'b1;
                        done_o      <= 1'b0;
                    end
                end
                RUN: begin
                    if (!step_issue) begin
                        state_q <= DRAIN;   // One idle cycle already spent
                    end
                end
                DRAIN: begin
                    state_q         <= READOUT;
                    readout_start_o <= 1'b1;
                end
                READOUT: begin
                    if (rdo_busy_q && !readout_busy_i) begin
                        state_q <= FINISH;
                    end
                end
                FINISH: begin
                    state_q <= IDLE;
                    done_o  <= 1'b1;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        step_addr_o <= step_q[dfr_pkg::STATE_AW-1:0];
    end

endmodule

// ==== logic/dfr_host_regs.sv ====
`timescale 1ns/1ps

module dfr_host_regs (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  dfr_pkg::host_addr_t         host_addr_i,
    input  logic                        host_wen_i,
    input  logic                        host_ren_i,
    input  dfr_pkg::host_data_t         host_wdata_i,
    output dfr_pkg::host_data_t         host_rdata_o,
    output logic                        host_rvalid_o,
    input  logic                        busy_i,
    input  logic                        done_i,
    output logic                        start_o,
    output logic [dfr_pkg::COUNT_W-1:0] count_o,
    dfr_mem_if.user                     input_a,
    dfr_mem_if.user                     weight_a,
    dfr_mem_if.user                     state_a,
    dfr_mem_if.user                     output_a
);

    logic [dfr_pkg::REGION_W-1:0] region;
    logic [dfr_pkg::OFFSET_W-1:0] offset;
    logic                         reg_wen;
    logic [dfr_pkg::REGION_W-1:0] rd_region_q;
    logic                         rd_busy_q;
    dfr_pkg::host_data_t          rd_reg_q;
    dfr_pkg::host_data_t          reg_rdata;
    dfr_pkg::host_data_t          mem_rdata;

    assign region  = host_addr_i[dfr_pkg::HOST_AW-1 -: dfr_pkg::REGION_W];
    assign offset  = host_addr_i[dfr_pkg::OFFSET_W-1:0];
    assign reg_wen = host_wen_i && (region == dfr_pkg::REG_REGION);
    assign start_o = reg_wen && (offset == dfr_pkg::CTRL_REG) && host_wdata_i[0] && !busy_i;

    // Memory windows, writes only while idle
    assign input_a.addr   = offset[dfr_pkg::SAMPLE_AW-1:0];
    assign input_a.wdata  = host_wdata_i[$bits(dfr_pkg::sample_t)-1:0];
    assign input_a.wen    = host_wen_i && (region == dfr_pkg::INPUT_REGION) && !busy_i;
    assign weight_a.addr  = offset[dfr_pkg::WEIGHT_AW-1:0];
    assign weight_a.wdata = host_wdata_i[$bits(dfr_pkg::weight_t)-1:0];
    assign weight_a.wen   = host_wen_i && (region == dfr_pkg::WEIGHT_REGION) && !busy_i;
    assign state_a.addr   = offset[dfr_pkg::STATE_AW-1:0];
    assign state_a.wdata  = '0;
    assign state_a.wen    = 1'b0;
    assign output_a.addr  = offset[dfr_pkg::SAMPLE_AW-1:0];
    assign output_a.wdata = '0;
    assign output_a.wen   = 1'b0;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_o       <= '0;
            host_rvalid_o <= 1'b0;
        end else begin
            host_rvalid_o <= host_ren_i;
            if (reg_wen && (offset == dfr_pkg::COUNT_REG)) begin
                count_o <= host_wdata_i[dfr_pkg::COUNT_W-1:0];
            end
        end
    end

    always_comb begin
        case (offset)
            dfr_pkg::COUNT_REG:  reg_rdata = dfr_pkg::host_data_t'(count_o);
            dfr_pkg::STATUS_REG: reg_rdata = {30'b0, done_i, busy_i};
            default:             reg_rdata = '0;
        endcase
    end

    // Region and register value captured with the read
    always_ff @(posedge clk_i) begin
        if (host_ren_i) begin
            rd_region_q <= region;
            rd_busy_q   <= busy_i;
            rd_reg_q    <= reg_rdata;
        end
    end

    always_comb begin
        case (rd_region_q)
            dfr_pkg::INPUT_REGION:  mem_rdata = dfr_pkg::host_data_t'(input_a.rdata);
            dfr_pkg::WEIGHT_REGION: mem_rdata = dfr_pkg::host_data_t'(weight_a.rdata);
            dfr_pkg::STATE_REGION:  mem_rdata = dfr_pkg::host_data_t'(state_a.rdata);
            dfr_pkg::OUTPUT_REGION: mem_rdata = dfr_pkg::host_data_t'(output_a.rdata);
            default:                mem_rdata = '0;
        endcase
    end

    assign host_rdata_o = (rd_region_q == dfr_pkg::REG_REGION) ? rd_reg_q :
                          (rd_busy_q ? '0 : mem_rdata);

endmodule

// ==== logic/dfr_dpram.sv ====
`timescale 1ns/1ps

module dfr_dpram #(
    parameter type word_t   = dfr_pkg::state_t,
    parameter int  DEPTH_AW = dfr_pkg::STATE_AW
) (
    input  logic   clk_i,
    dfr_mem_if.mem port_a,
    dfr_mem_if.mem port_b
);

    word_t mem_q [2**DEPTH_AW];

    always_ff @(posedge clk_i) begin
        if (port_a.wen) begin
            mem_q[port_a.addr] <= port_a.wdata;
        end
        // Port b wins a same-address clash
        if (port_b.wen) begin
            mem_q[port_b.addr] <= port_b.wdata;
        end
        port_a.rdata <= mem_q[port_a.addr];   // Read before write
        port_b.rdata <= mem_q[port_b.addr];
    end

endmodule

// ==== logic/dfr_mem_if.sv ====
`timescale 1ns/1ps

// One memory port, read data one cycle after addr
interface dfr_mem_if #(
    parameter type word_t = dfr_pkg::state_t,
    parameter int  ADDR_W = dfr_pkg::STATE_AW
);

    logic [ADDR_W-1:0] addr;
    word_t             wdata;
    logic              wen;
    word_t             rdata;

    modport user (output addr, output wdata, output wen, input rdata);
    modport mem  (input addr, input wdata, input wen, output rdata);

endinterface

// ==== logic/dfr_pkg.sv ====
package dfr_pkg;

    // Sizes
    localparam int NUM_NODES   = 8;
    localparam int MAX_SAMPLES = 64;
    localparam int SAMPLE_AW   = $clog2(MAX_SAMPLES);
    localparam int STATE_AW    = $clog2(MAX_SAMPLES * NUM_NODES);
    localparam int WEIGHT_AW   = $clog2(NUM_NODES);
    localparam int COUNT_W     = $clog2(MAX_SAMPLES + 1);   // 0 to MAX_SAMPLES
    localparam int STEP_W      = STATE_AW + 1;

    // Host bus
    localparam int HOST_AW  = 16;
    localparam int HOST_DW  = 32;
    localparam int REGION_W = 4;
    localparam int OFFSET_W = HOST_AW - REGION_W;

    typedef logic signed [15:0] sample_t;
    typedef logic signed [15:0] weight_t;
    typedef logic signed [31:0] state_t;
    typedef logic signed [47:0] prod_t;   // Full state x weight product
    typedef logic [HOST_AW-1:0] host_addr_t;
    typedef logic [HOST_DW-1:0] host_data_t;

    localparam logic [REGION_W-1:0] REG_REGION    = 4'd0;
    localparam logic [REGION_W-1:0] INPUT_REGION  = 4'd1;
    localparam logic [REGION_W-1:0] WEIGHT_REGION = 4'd2;
    localparam logic [REGION_W-1:0] STATE_REGION  = 4'd3;   // Host read only
    localparam logic [REGION_W-1:0] OUTPUT_REGION = 4'd4;   // Host read only

    localparam logic [OFFSET_W-1:0] CTRL_REG   = 12'd0;
    localparam logic [OFFSET_W-1:0] COUNT_REG  = 12'd1;
    localparam logic [OFFSET_W-1:0] STATUS_REG = 12'd2;

endpackage
